// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_core_l15_bridge \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

// File: source/core_l15_bridge.sv
`timescale 1ns/1ps

module core_l15_bridge
	import l15_pkg::*, core_pkg::*;
#(
	parameter word_t RESET_PC = 32'h0000_1000
)
(
	input logic clk,
	input logic nrst,

	input logic fetch_en,
	output logic instr_valid,
	output word_t instr,
	output word_t instr_pc,

	input logic mem_req,
	input logic mem_we,
	input word_t mem_addr,
	input word_t mem_wdata,
	output logic mem_busy,
	output logic mem_done,
	output word_t mem_rdata,

	// L1.5 request
	output rqtype_t l15_rqtype,
	output size_t l15_size,
	output l15_addr_t l15_address,
	output l15_data_t l15_data,
	output logic l15_val,
	input logic l15_header_ack,
	input logic l15_ack,

	// L1.5 response
	input logic l15_resp_val,
	input l15_data_t l15_data_0,
	input l15_data_t l15_data_1,
	input returntype_t l15_returntype,
	output logic l15_req_ack
);

	rqtype_t fetch_rqtype;
	size_t fetch_size;
	l15_addr_t fetch_address;
	logic fetch_val;
	logic fetch_req_ack;
	logic fetch_resp_wait;
	logic fetch_header_ack;
	logic fetch_resp_val;
	l15_data_t fetch_data_0;
	l15_data_t fetch_data_1;

	rqtype_t dmem_rqtype;
	size_t dmem_size;
	l15_addr_t dmem_address;
	l15_data_t dmem_data;
	logic dmem_val;
	logic dmem_req_ack;
	logic dmem_pending;
	logic dmem_header_ack;
	logic dmem_resp_val;
	l15_data_t dmem_data_0;
	l15_data_t dmem_data_1;

	fetch_port #(
		.RESET_PC(RESET_PC)
	) fetch_i (
		.clk(clk),
		.nrst(nrst),
		.fetch_en(fetch_en),
		.rqtype(fetch_rqtype),
		.size(fetch_size),
		.address(fetch_address),
		.val(fetch_val),
		.header_ack(fetch_header_ack),
		.resp_val(fetch_resp_val),
		.data_0(fetch_data_0),
		.data_1(fetch_data_1),
		.req_ack(fetch_req_ack),
		.resp_wait(fetch_resp_wait),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc)
	);

	data_mem_port dmem_i (
		.clk(clk),
		.nrst(nrst),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_busy(mem_busy),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.rqtype(dmem_rqtype),
		.size(dmem_size),
		.address(dmem_address),
		.data(dmem_data),
		.val(dmem_val),
		.header_ack(dmem_header_ack),
		.resp_val(dmem_resp_val),
		.data_0(dmem_data_0),
		.data_1(dmem_data_1),
		.req_ack(dmem_req_ack),
		.pending(dmem_pending)
	);

	port_arbiter arb_i (
		.clk(clk),
		.nrst(nrst),
		.fetch_rqtype(fetch_rqtype),
		.fetch_size(fetch_size),
		.fetch_address(fetch_address),
		.fetch_val(fetch_val),
		.fetch_req_ack(fetch_req_ack),
		.fetch_resp_wait(fetch_resp_wait),
		.fetch_header_ack(fetch_header_ack),
		.fetch_resp_val(fetch_resp_val),
		.fetch_data_0(fetch_data_0),
		.fetch_data_1(fetch_data_1),
		.dmem_rqtype(dmem_rqtype),
		.dmem_size(dmem_size),
		.dmem_address(dmem_address),
		.dmem_data(dmem_data),
		.dmem_val(dmem_val),
		.dmem_req_ack(dmem_req_ack),
		.dmem_pending(dmem_pending),
		.dmem_done(mem_done),
		.dmem_header_ack(dmem_header_ack),
		.dmem_resp_val(dmem_resp_val),
		.dmem_data_0(dmem_data_0),
		.dmem_data_1(dmem_data_1),
		.l15_rqtype(l15_rqtype),
		.l15_size(l15_size),
		.l15_address(l15_address),
		.l15_data(l15_data),
		.l15_val(l15_val),
		.l15_header_ack(l15_header_ack),
		.l15_resp_val(l15_resp_val),
		.l15_data_0(l15_data_0),
		.l15_data_1(l15_data_1),
		.l15_req_ack(l15_req_ack)
	);

	// Response type has to match the request of whoever owns the port
	assert property (@(posedge clk) disable iff (!nrst)
		l15_resp_val |-> l15_returntype ==
			((dmem_resp_val && dmem_rqtype == STORE_RQ) ? ST_ACK : LOAD_RET));

	// Cache ack only together with taking the header
	assert property (@(posedge clk) disable iff (!nrst)
		l15_ack |-> l15_header_ack);

endmodule

// File: source/core_pkg.sv
package core_pkg;

	// Instruction or data word, also used for core-side addresses
	typedef logic [31:0] word_t;

	// Owner of the single L1.5 port
	typedef enum logic [1:0]
	{
		ARB_INSTR,
		ARB_WAIT,
		ARB_MEM
	} arb_state_t;

	// Request progress of one requester
	typedef enum logic [1:0]
	{
		P_IDLE,
		P_REQ,
		P_RESP
	} port_state_t;

endpackage

// File: source/data_mem_port.sv
`timescale 1ns/1ps

module data_mem_port
	import l15_pkg::*, core_pkg::*;
(
	input logic clk,
	input logic nrst,

	// Core-side command
	input logic mem_req,
	input logic mem_we,
	input word_t mem_addr,
	input word_t mem_wdata,
	output logic mem_busy,
	output logic mem_done,
	output word_t mem_rdata,

	// L1.5 request
	output rqtype_t rqtype,
	output size_t size,
	output l15_addr_t address,
	output l15_data_t data,
	output logic val,
	input logic header_ack,

	// L1.5 response
	input logic resp_val,
	input l15_data_t data_0,
	input l15_data_t data_1,
	output logic req_ack,

	// Command held, for the arbiter
	output logic pending
);

	port_state_t state;

	// Latched command
	logic cmd_we;
	word_t cmd_addr;
	word_t cmd_wdata;

	assign rqtype = cmd_we ? STORE_RQ : LOAD_RQ;
	assign size = SIZE_WORD;
	assign address = cmd_addr;
	// Store word copied into both halves of the lane
	assign data = {cmd_wdata, cmd_wdata};

	assign val = (state == P_REQ);
	assign req_ack = (state == P_RESP) && resp_val;
	assign pending = (state != P_IDLE);
	assign mem_busy = pending;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= P_IDLE;
			mem_done <= 1'b0;
		end
		else
		begin
			mem_done <= 1'b0;
			case (state)
				P_IDLE:
				begin
					if (mem_req)
						state <= P_REQ;
				end
				P_REQ:
				begin
					if (header_ack)
						state <= P_RESP;
				end
				P_RESP:
				begin
					if (resp_val)
					begin
						mem_done <= 1'b1;
						state <= P_IDLE;
					end
				end
				default:
					state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == P_IDLE && mem_req)
		begin
			cmd_we <= mem_we;
			cmd_addr <= mem_addr;
			cmd_wdata <= mem_wdata;
		end
		// Store acks carry no useful lane, value ignored by the core
		if (req_ack)
			mem_rdata <= select_word(data_0, data_1, cmd_addr[3:2]);
	end

	// Core must wait for the previous command to finish
	assert property (@(posedge clk) disable iff (!nrst)
		mem_busy |-> !mem_req);

endmodule

// File: source/fetch_port.sv
`timescale 1ns/1ps

module fetch_port
	import l15_pkg::*, core_pkg::*;
#(
	parameter word_t RESET_PC = 32'h0000_0000
)
(
	input logic clk,
	input logic nrst,
	input logic fetch_en,

	// L1.5 request
	output rqtype_t rqtype,
	output size_t size,
	output l15_addr_t address,
	output logic val,
	input logic header_ack,

	// L1.5 response
	input logic resp_val,
	input l15_data_t data_0,
	input l15_data_t data_1,
	output logic req_ack,

	// Fetch in flight, seen by the arbiter
	output logic resp_wait,

	output logic instr_valid,
	output word_t instr,
	output word_t instr_pc
);

	port_state_t state;
	word_t pc;

	// Fetch only ever reads whole words
	assign rqtype = LOAD_RQ;
	assign size = SIZE_WORD;
	assign address = pc;

	assign val = (state == P_REQ);
	assign req_ack = (state == P_RESP) && resp_val;
	assign resp_wait = (state == P_RESP);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= P_IDLE;
			pc <= RESET_PC;
			instr_valid <= 1'b0;
		end
		else
		begin
			instr_valid <= 1'b0;
			case (state)
				P_IDLE:
				begin
					if (fetch_en)
						state <= P_REQ;
				end
				P_REQ:
				begin
					if (header_ack)
						state <= P_RESP;
				end
				P_RESP:
				begin
					if (resp_val)
					begin
						instr_valid <= 1'b1;
						pc <= pc + 32'd4;
						// Next fetch goes out straight away when still enabled
						state <= fetch_en ? P_REQ : P_IDLE;
					end
				end
				default:
					state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_ack)
		begin
			instr <= select_word(data_0, data_1, pc[3:2]);
			instr_pc <= pc;
		end
	end

	// A request not yet taken by the cache stays put
	assert property (@(posedge clk) disable iff (!nrst)
		val && !header_ack |=> val && $stable(address));

endmodule

// File: source/l15_pkg.sv
package l15_pkg;

	// Request side fields
	typedef logic [4:0] rqtype_t;
	typedef logic [2:0] size_t;
	typedef logic [31:0] l15_addr_t;
	typedef logic [63:0] l15_data_t;

	localparam rqtype_t LOAD_RQ = 5'd0;
	localparam rqtype_t STORE_RQ = 5'd1;

	// 4-byte access
	localparam size_t SIZE_WORD = 3'd2;

	// Response side fields
	typedef logic [3:0] returntype_t;

	localparam returntype_t LOAD_RET = 4'd0;
	localparam returntype_t ST_ACK = 4'd4;

	// Word at address bits [3:2] out of the two 64-bit response lanes
	function automatic logic [31:0] select_word(
		input l15_data_t lane_0,
		input l15_data_t lane_1,
		input logic [1:0] sel
	);
		logic [127:0] lanes;
		lanes = {lane_1, lane_0};
		return lanes[sel * 32 +: 32];
	endfunction

endpackage

// File: source/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter
	import l15_pkg::*, core_pkg::*;
(
	input logic clk,
	input logic nrst,

	// Fetch side
	input rqtype_t fetch_rqtype,
	input size_t fetch_size,
	input l15_addr_t fetch_address,
	input logic fetch_val,
	input logic fetch_req_ack,
	input logic fetch_resp_wait,
	output logic fetch_header_ack,
	output logic fetch_resp_val,
	output l15_data_t fetch_data_0,
	output l15_data_t fetch_data_1,

	// Data side
	input rqtype_t dmem_rqtype,
	input size_t dmem_size,
	input l15_addr_t dmem_address,
	input l15_data_t dmem_data,
	input logic dmem_val,
	input logic dmem_req_ack,
	input logic dmem_pending,
	input logic dmem_done,
	output logic dmem_header_ack,
	output logic dmem_resp_val,
	output l15_data_t dmem_data_0,
	output l15_data_t dmem_data_1,

	// The one L1.5 port
	output rqtype_t l15_rqtype,
	output size_t l15_size,
	output l15_addr_t l15_address,
	output l15_data_t l15_data,
	output logic l15_val,
	input logic l15_header_ack,
	input logic l15_resp_val,
	input l15_data_t l15_data_0,
	input l15_data_t l15_data_1,
	output logic l15_req_ack
);

	arb_state_t state;
	logic mem_owns;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= ARB_INSTR;
		else
		begin
			case (state)
				ARB_INSTR:
				begin
					if (dmem_pending)
						state <= ARB_WAIT;
				end
				ARB_WAIT:
				begin
					// Let the fetch in flight come back first
					if (!fetch_resp_wait || l15_resp_val)
						state <= ARB_MEM;
				end
				ARB_MEM:
				begin
					if (dmem_done)
						state <= ARB_INSTR;
				end
				default:
					state <= ARB_INSTR;
			endcase
		end
	end

	assign mem_owns = (state == ARB_MEM);

	always_comb
	begin
		if (mem_owns)
		begin
			l15_rqtype = dmem_rqtype;
			l15_size = dmem_size;
			l15_address = dmem_address;
			l15_data = dmem_data;
			l15_val = dmem_val;
			l15_req_ack = dmem_req_ack;
		end
		else
		begin
			l15_rqtype = fetch_rqtype;
			l15_size = fetch_size;
			l15_address = fetch_address;
			l15_data = '0;
			// No new request while draining the fetch
			l15_val = fetch_val && (state == ARB_INSTR);
			l15_req_ack = fetch_req_ack;
		end
		fetch_header_ack = l15_header_ack && (state == ARB_INSTR);
		dmem_header_ack = l15_header_ack && mem_owns;
		// Responses in ARB_WAIT still belong to fetch
		fetch_resp_val = l15_resp_val && !mem_owns;
		dmem_resp_val = l15_resp_val && mem_owns;
		fetch_data_0 = mem_owns ? '0 : l15_data_0;
		fetch_data_1 = mem_owns ? '0 : l15_data_1;
		dmem_data_0 = mem_owns ? l15_data_0 : '0;
		dmem_data_1 = mem_owns ? l15_data_1 : '0;
	end

	// Data side only gets the port for a command it still holds
	assert property (@(posedge clk) disable iff (!nrst)
		(state != ARB_MEM) ##1 (state == ARB_MEM) |-> dmem_pending);

	assert property (@(posedge clk) disable iff (!nrst)
		(state == ARB_WAIT) |-> !l15_val);

endmodule

// File: verif/l15_model.sv
`timescale 1ns/1ps

module l15_model
	import l15_pkg::*;
#(
	parameter logic [31:0] SEED = 32'hfe6e
)
(
	input logic clk,
	input logic nrst,

	// Request side
	input rqtype_t l15_rqtype,
	input l15_addr_t l15_address,
	input l15_data_t l15_data,
	input logic l15_val,
	output logic l15_header_ack,
	output logic l15_ack,

	// Response side
	output logic l15_resp_val,
	output l15_data_t l15_data_0,
	output l15_data_t l15_data_1,
	output returntype_t l15_returntype
);

	// Sparse word memory keyed by byte address
	logic [31:0] mem [l15_addr_t];

	logic [31:0] rng;
	logic busy;
	logic [1:0] hdr_wait;
	logic [1:0] resp_wait;
	logic req_store;
	logic take;
	l15_data_t lane_0;
	l15_data_t lane_1;
	l15_addr_t word_addr;
	l15_addr_t block_addr;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Unwritten words read back as a pattern of their address
	function automatic logic [31:0] read_word(input l15_addr_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'h5a5a_0000;
	endfunction

	assign word_addr = {l15_address[31:2], 2'b00};
	assign block_addr = {l15_address[31:4], 4'h0};

	// Ready to take a header once the drawn delay has run out
	assign l15_header_ack = !busy && (hdr_wait == 2'd0);
	assign l15_ack = l15_header_ack;
	assign take = l15_val && l15_header_ack;

	assign l15_resp_val = busy && (resp_wait == 2'd0);
	assign l15_returntype = req_store ? ST_ACK : LOAD_RET;
	assign l15_data_0 = (l15_resp_val && !req_store) ? lane_0 : '0;
	assign l15_data_1 = (l15_resp_val && !req_store) ? lane_1 : '0;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rng <= SEED;
			busy <= 1'b0;
			hdr_wait <= 2'd0;
			resp_wait <= 2'd0;
			req_store <= 1'b0;
		end
		else if (!busy)
		begin
			if (take)
			begin
				busy <= 1'b1;
				req_store <= (l15_rqtype == STORE_RQ);
				resp_wait <= rng[17:16];
				rng <= lcg_step(rng);
			end
			// Delay only counts cycles with a request on the port
			else if (l15_val && hdr_wait != 2'd0)
				hdr_wait <= hdr_wait - 2'd1;
		end
		else if (l15_resp_val)
		begin
			busy <= 1'b0;
			hdr_wait <= rng[17:16];
			rng <= lcg_step(rng);
		end
		else
			resp_wait <= resp_wait - 2'd1;
	end

	// Memory access happens when the header is taken
	always @(posedge clk)
	begin
		if (nrst && take)
		begin
			if (l15_rqtype == STORE_RQ)
				mem[word_addr] = l15_data[31:0];
			else
			begin
				lane_0 <= {read_word(block_addr + 32'd4), read_word(block_addr)};
				lane_1 <= {read_word(block_addr + 32'd12), read_word(block_addr + 32'd8)};
			end
		end
	end

endmodule

// File: verif/tb_core_l15_bridge.sv
`timescale 1ns/1ps

module tb_core_l15_bridge
	import l15_pkg::*, core_pkg::*;
();

	localparam word_t RESET_PC = 32'h0000_1000;
	// Data accesses stay clear of the fetched code
	localparam word_t DATA_BASE = 32'h0000_8000;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic nrst;
	logic fetch_en;
	logic instr_valid;
	word_t instr;
	word_t instr_pc;
	logic mem_req;
	logic mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	logic mem_busy;
	logic mem_done;
	word_t mem_rdata;

	rqtype_t l15_rqtype;
	size_t l15_size;
	l15_addr_t l15_address;
	l15_data_t l15_data;
	logic l15_val;
	logic l15_header_ack;
	logic l15_ack;
	logic l15_resp_val;
	l15_data_t l15_data_0;
	l15_data_t l15_data_1;
	returntype_t l15_returntype;
	logic l15_req_ack;

	// Reference state
	logic [31:0] rng;
	word_t stored [word_t];
	logic cmd_we;
	word_t cmd_addr;
	word_t cmd_wdata;
	word_t exp_rdata;
	logic cmd_open;
	word_t exp_pc;
	int fetch_count;
	int owed;
	logic quiet;

	core_l15_bridge #(
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk(clk),
		.nrst(nrst),
		.fetch_en(fetch_en),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_busy(mem_busy),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.l15_rqtype(l15_rqtype),
		.l15_size(l15_size),
		.l15_address(l15_address),
		.l15_data(l15_data),
		.l15_val(l15_val),
		.l15_header_ack(l15_header_ack),
		.l15_ack(l15_ack),
		.l15_resp_val(l15_resp_val),
		.l15_data_0(l15_data_0),
		.l15_data_1(l15_data_1),
		.l15_returntype(l15_returntype),
		.l15_req_ack(l15_req_ack)
	);

	l15_model #(
		.SEED(32'hfe6e)
	) cache_i (
		.clk(clk),
		.nrst(nrst),
		.l15_rqtype(l15_rqtype),
		.l15_address(l15_address),
		.l15_data(l15_data),
		.l15_val(l15_val),
		.l15_header_ack(l15_header_ack),
		.l15_ack(l15_ack),
		.l15_resp_val(l15_resp_val),
		.l15_data_0(l15_data_0),
		.l15_data_1(l15_data_1),
		.l15_returntype(l15_returntype)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t unwritten_word(input word_t addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on a failed check");
	endtask

	task automatic wait_fetches(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles = cycles + 1;
			if (instr_valid)
			begin
				seen = seen + 1;
				cycles = 0;
			end
		end
		if (seen < count)
			fail_run("Timed out waiting for instr_valid");
	endtask

	// One load or store, returns after mem_done
	task automatic run_command(input logic we, input word_t addr, input word_t wdata);
		int cycles;
		@(negedge clk);
		mem_req = 1'b1;
		mem_we = we;
		mem_addr = addr;
		mem_wdata = wdata;
		cmd_we = we;
		cmd_addr = addr;
		cmd_wdata = wdata;
		if (we)
			stored[addr] = wdata;
		else
			exp_rdata = stored.exists(addr) ? stored[addr] : unwritten_word(addr);
		@(negedge clk);
		mem_req = 1'b0;
		cycles = 0;
		while (!mem_done && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!mem_done)
			fail_run("Timed out waiting for mem_done");
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			exp_pc <= RESET_PC;
			fetch_count <= 0;
			cmd_open <= 1'b0;
			owed <= 0;
		end
		else
		begin
			if (instr_valid)
			begin
				exp_pc <= exp_pc + 32'd4;
				fetch_count <= fetch_count + 1;
			end
			if (mem_req)
				cmd_open <= 1'b1;
			else if (mem_done)
				cmd_open <= 1'b0;
			if (l15_val && l15_header_ack)
				owed <= owed + 1;
			else if (l15_resp_val)
				owed <= owed - 1;
		end
	end

	assign quiet = !l15_val && !l15_req_ack && !instr_valid && !mem_done && !mem_busy;

	// Outputs stay low in reset and in the first cycle after it
	assert property (@(posedge clk) (!nrst || !$past(nrst)) |-> quiet)
		else fail_run($sformatf("[ERROR] %0t: outputs active around reset", $time));

	assert property (@(posedge clk) disable iff (!nrst) instr_valid |-> instr_pc == exp_pc)
		else fail_run($sformatf("[ERROR] %0t: instr_pc %h, expected %h", $time,
			$sampled(instr_pc), $sampled(exp_pc)));

	assert property (@(posedge clk) disable iff (!nrst)
		instr_valid |-> instr == unwritten_word(exp_pc))
		else fail_run($sformatf("[ERROR] %0t: instr %h at pc %h", $time,
			$sampled(instr), $sampled(exp_pc)));

	assert property (@(posedge clk) disable iff (!nrst)
		mem_done && !cmd_we |-> mem_rdata == exp_rdata)
		else fail_run($sformatf("[ERROR] %0t: load of %h returned %h, expected %h", $time,
			$sampled(cmd_addr), $sampled(mem_rdata), $sampled(exp_rdata)));

	assert property (@(posedge clk) disable iff (!nrst) mem_done |-> cmd_open)
		else fail_run($sformatf("[ERROR] %0t: mem_done without a command", $time));

	// Busy from the cycle after mem_req until the command is done
	assert property (@(posedge clk) disable iff (!nrst)
		mem_busy == (cmd_open && !mem_done))
		else fail_run($sformatf("[ERROR] %0t: mem_busy %b out of step with the command",
			$time, $sampled(mem_busy)));

	// At most one request owed and none started while one is owed
	assert property (@(posedge clk) disable iff (!nrst) l15_val |-> owed == 0)
		else fail_run($sformatf("[ERROR] %0t: request with %0d responses owed", $time,
			$sampled(owed)));

	assert property (@(posedge clk) disable iff (!nrst) l15_resp_val |-> owed == 1)
		else fail_run($sformatf("[ERROR] %0t: response with %0d responses owed", $time,
			$sampled(owed)));

	assert property (@(posedge clk) disable iff (!nrst) l15_resp_val == l15_req_ack)
		else fail_run($sformatf("[ERROR] %0t: req_ack not paired with resp_val", $time));

	// Every request is a word load or a word store
	assert property (@(posedge clk) disable iff (!nrst)
		l15_val |-> l15_size == SIZE_WORD
			&& (l15_rqtype == LOAD_RQ || l15_rqtype == STORE_RQ))
		else fail_run($sformatf("[ERROR] %0t: request type %h size %h", $time,
			$sampled(l15_rqtype), $sampled(l15_size)));

	assert property (@(posedge clk) disable iff (!nrst)
		l15_val && l15_rqtype == STORE_RQ |->
			l15_data == {cmd_wdata, cmd_wdata} && l15_address == cmd_addr)
		else fail_run($sformatf("[ERROR] %0t: store request fields wrong", $time));

	initial
	begin
		int i;
		int gap;
		logic we;
		word_t addr;
		word_t wdata;
		nrst = 1'b1;
		fetch_en = 1'b0;
		mem_req = 1'b0;
		mem_we = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		cmd_we = 1'b0;
		cmd_addr = '0;
		cmd_wdata = '0;
		exp_rdata = '0;
		rng = 32'hfe6e;
		#1 nrst = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		repeat (3) @(negedge clk);

		fetch_en = 1'b1;
		wait_fetches(8);

		run_command(1'b0, DATA_BASE + 32'h100, 32'h0);
		run_command(1'b1, DATA_BASE + 32'h104, 32'hc0de_1234);
		run_command(1'b0, DATA_BASE + 32'h104, 32'h0);

		// Random mix over sixteen words while fetch keeps running
		for (i = 0; i < 40; i = i + 1)
		begin
			rng = lcg_next(rng);
			gap = int'(rng[23:22]);
			we = rng[20];
			addr = DATA_BASE | {26'd0, rng[19:16], 2'b00};
			rng = lcg_next(rng);
			wdata = rng;
			repeat (gap) @(negedge clk);
			run_command(we, addr, wdata);
		end
		wait_fetches(4);

		// Fetcher idle, data side has the port alone
		fetch_en = 1'b0;
		repeat (10) @(negedge clk);
		run_command(1'b0, DATA_BASE + 32'h104, 32'h0);
		repeat (4) @(negedge clk);

		if (fetch_count > 16)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			fail_run("Too few instruction fetches were seen");
	end

endmodule

// File: vlog.f
source/l15_pkg.sv
source/core_pkg.sv
source/fetch_port.sv
source/data_mem_port.sv
source/port_arbiter.sv
source/core_l15_bridge.sv
verif/l15_model.sv
verif/tb_core_l15_bridge.sv
